//--- dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // access kind
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // size shapes at offset zero
    // the low address bits move them to the addressed byte
    localparam logic [3:0] STRB_BYTE = 4'b0001;
    localparam logic [3:0] STRB_HALF = 4'b0011;
    localparam logic [3:0] STRB_WORD = 4'b1111;

    // one pipeline request, 70 bits
    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;   // store data, low aligned
        logic [3:0]        strb;    // one of the STRB_* shapes
        logic              sext;    // sign extend on load
    } cpu_req_t;

endpackage

//--- dcache_req_latch.sv
`timescale 1ns/1ps

module dcache_req_latch #(
    parameter  int WORD_OFFSET_WIDTH = 4,
    localparam int LINE_W            = dcache_pkg::DATA_W << WORD_OFFSET_WIDTH
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  dcache_pkg::cpu_req_t i_req,
    input  logic                 i_take,
    output dcache_pkg::cpu_req_t o_lat_req,
    output logic [LINE_W/8-1:0]  o_line_be,
    output logic [LINE_W-1:0]    o_line_wdata
);
    import dcache_pkg::*;

    localparam int OFF_W = WORD_OFFSET_WIDTH + 2;

    logic [OFF_W-1:0] byte_off;   // byte position inside the line

    always_ff @(posedge clk) begin
        if (!rstn)
            o_lat_req <= '0;
        else if (i_take)
            o_lat_req <= i_req;
    end

    assign byte_off = o_lat_req.addr[OFF_W-1:0];

    // loads carry no enables, so a refill of a load line stays untouched
    assign o_line_be = (o_lat_req.op == OP_WRITE) ?
        {{(LINE_W/8-4){1'b0}}, o_lat_req.strb} << byte_off : '0;
    assign o_line_wdata =
        {{(LINE_W-DATA_W){1'b0}}, o_lat_req.wdata} << {byte_off, 3'b000};

endmodule

//--- dcache_tag_ways.sv
`timescale 1ns/1ps

module dcache_tag_ways #(
    parameter int INDEX_WIDTH       = 6,
    parameter int WORD_OFFSET_WIDTH = 4
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [INDEX_WIDTH-1:0]        i_rd_index,
    input  dcache_pkg::cpu_req_t          i_lat_req,
    input  logic                          i_tag_we,
    input  logic                          i_dirty_set,
    input  logic                          i_dirty_clr,
    input  logic                          i_lru_touch,
    input  logic                          i_way_sel,
    output logic                          o_hit,
    output logic                          o_hit_way,
    output logic                          o_victim_way,
    output logic                          o_victim_dirty,
    output logic [dcache_pkg::ADDR_W-1:0] o_victim_addr
);
    import dcache_pkg::*;

    localparam int OFF_W = WORD_OFFSET_WIDTH + 2;
    localparam int TAG_W = ADDR_W - INDEX_WIDTH - OFF_W;
    localparam int SETS  = 1 << INDEX_WIDTH;

    logic [TAG_W-1:0]       tag_mem [2][SETS];
    logic [1:0][SETS-1:0]   valid;
    logic [1:0][SETS-1:0]   dirty;
    logic [SETS-1:0]        lru;        // most recently used way
    logic [1:0][TAG_W-1:0]  tag_q;
    logic [1:0]             valid_q;
    logic [1:0]             hit_vec;
    logic [INDEX_WIDTH-1:0] lat_index;
    logic [TAG_W-1:0]       lat_tag;

    assign lat_index = i_lat_req.addr[OFF_W +: INDEX_WIDTH];
    assign lat_tag   = i_lat_req.addr[ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk) begin
        if (i_tag_we)
            tag_mem[i_way_sel][lat_index] <= lat_tag;
        tag_q[0] <= tag_mem[0][i_rd_index];   // sync read, one cycle
        tag_q[1] <= tag_mem[1][i_rd_index];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid   <= '0;
            dirty   <= '0;
            lru     <= '0;
            valid_q <= '0;
        end else begin
            valid_q <= {valid[1][i_rd_index], valid[0][i_rd_index]};
            if (i_tag_we)
                valid[i_way_sel][lat_index] <= 1'b1;
            if (i_dirty_set)
                dirty[i_way_sel][lat_index] <= 1'b1;
            else if (i_dirty_clr)
                dirty[i_way_sel][lat_index] <= 1'b0;
            if (i_lru_touch)
                lru[lat_index] <= i_way_sel;
        end
    end

    assign hit_vec[0] = valid_q[0] && (tag_q[0] == lat_tag);
    assign hit_vec[1] = valid_q[1] && (tag_q[1] == lat_tag);
    assign o_hit      = |hit_vec;
    assign o_hit_way  = hit_vec[1];

    // empty way first, then the one not used last
    always_comb begin
        if (!valid_q[0])
            o_victim_way = 1'b0;
        else if (!valid_q[1])
            o_victim_way = 1'b1;
        else
            o_victim_way = ~lru[lat_index];
    end

    assign o_victim_dirty = dirty[o_victim_way][lat_index];
    assign o_victim_addr  = {tag_q[o_victim_way], lat_index, {OFF_W{1'b0}}};

    // a refill only installs a missing tag, so one line never sits in both ways
    assert property (@(posedge clk) disable iff (!rstn) !(hit_vec[0] && hit_vec[1]));

endmodule

//--- dcache_data_ways.sv
`timescale 1ns/1ps

module dcache_data_ways #(
    parameter  int INDEX_WIDTH       = 6,
    parameter  int WORD_OFFSET_WIDTH = 4,
    localparam int LINE_W            = dcache_pkg::DATA_W << WORD_OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic [INDEX_WIDTH-1:0] i_rd_index,
    input  logic [INDEX_WIDTH-1:0] i_wr_index,
    input  logic                   i_store_we,
    input  logic                   i_refill_we,
    input  logic                   i_way_sel,
    input  logic [LINE_W/8-1:0]    i_line_be,
    input  logic [LINE_W-1:0]      i_line_wdata,
    input  logic [LINE_W-1:0]      i_refill_line,
    output logic [LINE_W-1:0]      o_way0_line,
    output logic [LINE_W-1:0]      o_way1_line
);
    localparam int SETS   = 1 << INDEX_WIDTH;
    localparam int NBYTES = LINE_W / 8;

    logic [LINE_W-1:0] wr_line;
    logic              fwd;

    // store bytes over the returned line
    always_comb begin
        for (int b = 0; b < NBYTES; b++)
            wr_line[b*8 +: 8] = i_line_be[b] ? i_line_wdata[b*8 +: 8] : i_refill_line[b*8 +: 8];
    end

    assign fwd = (i_rd_index == i_wr_index);   // write and read hit the same set

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [LINE_W-1:0] mem [SETS];
        logic [LINE_W-1:0] rd_line;
        logic [NBYTES-1:0] wr_be;

        assign wr_be = (i_way_sel != 1'(w)) ? '0 :
                       i_refill_we ? '1 :
                       i_store_we ? i_line_be : '0;

        always_ff @(posedge clk) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (wr_be[b])
                    mem[i_wr_index][b*8 +: 8] <= wr_line[b*8 +: 8];
                if (wr_be[b] && fwd)
                    rd_line[b*8 +: 8] <= wr_line[b*8 +: 8];   // new byte, not the stale one
                else
                    rd_line[b*8 +: 8] <= mem[i_rd_index][b*8 +: 8];
            end
        end
    end

    assign o_way0_line = g_way[0].rd_line;
    assign o_way1_line = g_way[1].rd_line;

endmodule

//--- dcache_miss_ctrl.sv
`timescale 1ns/1ps

module dcache_miss_ctrl #(
    parameter  int WORD_OFFSET_WIDTH = 4,
    localparam int LINE_W            = dcache_pkg::DATA_W << WORD_OFFSET_WIDTH
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_valid,
    input  dcache_pkg::cpu_req_t          i_lat_req,
    input  logic                          i_hit,
    input  logic                          i_hit_way,
    input  logic                          i_victim_way,
    input  logic                          i_victim_dirty,
    input  logic [dcache_pkg::ADDR_W-1:0] i_victim_addr,
    input  logic [LINE_W-1:0]             i_way0_line,
    input  logic [LINE_W-1:0]             i_way1_line,
    input  logic                          i_mem_rready,
    input  logic [LINE_W-1:0]             i_mem_rdata,
    input  logic                          i_mem_wready,
    output logic                          o_take,
    output logic                          o_tag_we,
    output logic                          o_dirty_set,
    output logic                          o_dirty_clr,
    output logic                          o_lru_touch,
    output logic                          o_way_sel,
    output logic                          o_store_we,
    output logic                          o_refill_we,
    output logic [LINE_W-1:0]             o_refill_line,
    output logic [LINE_W-1:0]             o_sel_line,
    output logic                          o_idle,
    output logic                          o_rready,
    output logic                          o_wready,
    output logic                          o_mem_rvalid,
    output logic [dcache_pkg::ADDR_W-1:0] o_mem_raddr,
    output logic                          o_mem_wvalid,
    output logic [dcache_pkg::ADDR_W-1:0] o_mem_waddr,
    output logic [LINE_W-1:0]             o_mem_wdata
);
    import dcache_pkg::*;

    localparam int OFF_W = WORD_OFFSET_WIDTH + 2;

    typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_MISS, S_REFILL, S_WAIT} state_e;
    typedef enum logic [1:0] {WB_INIT, WB_WRITE, WB_FINISH} wb_state_e;

    state_e            state;
    state_e            state_nxt;
    wb_state_e         wb_state;
    wb_state_e         wb_state_nxt;
    logic              is_write;
    logic              lookup_hit;
    logic              lookup_miss;
    logic              done;          // current request answered
    logic              victim_way_q;
    logic [ADDR_W-1:0] wb_addr_q;
    logic [LINE_W-1:0] wbuf;          // write-back buffer
    logic [LINE_W-1:0] ret_buf;       // return buffer

    assign is_write    = (i_lat_req.op == OP_WRITE);
    assign lookup_hit  = (state == S_LOOKUP) && i_hit;
    assign lookup_miss = (state == S_LOOKUP) && !i_hit;
    assign done        = lookup_hit || (state == S_WAIT && wb_state == WB_FINISH);

    assign o_idle   = (state == S_IDLE);
    assign o_rready = done && !is_write;
    assign o_wready = done && is_write;
    assign o_take   = i_valid && (o_idle || done);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (o_take) state_nxt = S_LOOKUP;
            S_LOOKUP: state_nxt = !i_hit ? S_MISS : (o_take ? S_LOOKUP : S_IDLE);
            S_MISS:   if (i_mem_rready) state_nxt = S_REFILL;
            S_REFILL: state_nxt = S_WAIT;
            S_WAIT:   if (done) state_nxt = o_take ? S_LOOKUP : S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    // write-back runs beside the refill read
    always_comb begin
        wb_state_nxt = wb_state;
        case (wb_state)
            WB_INIT:   if (lookup_miss) wb_state_nxt = i_victim_dirty ? WB_WRITE : WB_FINISH;
            WB_WRITE:  if (i_mem_wready) wb_state_nxt = WB_FINISH;
            WB_FINISH: if (state == S_WAIT) wb_state_nxt = WB_INIT;
            default:   wb_state_nxt = WB_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= S_IDLE;
            wb_state <= WB_INIT;
        end else begin
            state    <= state_nxt;
            wb_state <= wb_state_nxt;
        end
    end

    // victim is only visible in the lookup cycle
    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            victim_way_q <= i_victim_way;
            wb_addr_q    <= i_victim_addr;
            wbuf         <= i_victim_way ? i_way1_line : i_way0_line;
        end
        if (o_mem_rvalid && i_mem_rready)
            ret_buf <= i_mem_rdata;
    end

    assign o_way_sel     = (state == S_LOOKUP) ? i_hit_way : victim_way_q;
    assign o_store_we    = lookup_hit && is_write;
    assign o_refill_we   = (state == S_REFILL);
    assign o_tag_we      = o_refill_we;
    assign o_lru_touch   = lookup_hit || o_refill_we;
    assign o_dirty_set   = o_store_we || (o_refill_we && is_write);   // merged store
    assign o_dirty_clr   = o_refill_we && !is_write;
    assign o_refill_line = ret_buf;
    assign o_sel_line    = (state != S_LOOKUP) ? ret_buf :
                           i_hit_way ? i_way1_line : i_way0_line;

    assign o_mem_rvalid = (state == S_MISS);
    assign o_mem_raddr  = {i_lat_req.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign o_mem_wvalid = (wb_state == WB_WRITE);
    assign o_mem_waddr  = wb_addr_q;
    assign o_mem_wdata  = wbuf;

    // memory request held with a stable address until accepted
    assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> o_mem_rvalid && $stable(o_mem_raddr));
    assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wvalid && !i_mem_wready |=> o_mem_wvalid && $stable(o_mem_waddr));

    // a dirty victim is valid and missed, so it never is the line being fetched
    assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && o_mem_wvalid |-> o_mem_raddr != o_mem_waddr);

endmodule

//--- dcache_load_align.sv
`timescale 1ns/1ps

module dcache_load_align #(
    parameter  int WORD_OFFSET_WIDTH = 4,
    localparam int LINE_W            = dcache_pkg::DATA_W << WORD_OFFSET_WIDTH
) (
    input  logic [LINE_W-1:0]             i_line,
    input  dcache_pkg::cpu_req_t          i_lat_req,
    output logic [dcache_pkg::DATA_W-1:0] o_rdata
);
    import dcache_pkg::*;

    logic [WORD_OFFSET_WIDTH-1:0] word_idx;
    logic [DATA_W-1:0]            word;
    logic [7:0]                   byte_val;
    logic [15:0]                  half_val;
    logic                         ext;

    assign word_idx = i_lat_req.addr[WORD_OFFSET_WIDTH+1:2];
    assign word     = i_line[word_idx*DATA_W +: DATA_W];
    assign byte_val = word[i_lat_req.addr[1:0]*8 +: 8];
    assign half_val = word[i_lat_req.addr[1]*16 +: 16];   // aligned halves only
    assign ext      = i_lat_req.sext;

    always_comb begin
        case (i_lat_req.strb)
            STRB_BYTE: o_rdata = {{24{byte_val[7] & ext}}, byte_val};
            STRB_HALF: o_rdata = {{16{half_val[15] & ext}}, half_val};
            STRB_WORD: o_rdata = word;
            default:   o_rdata = '0;
        endcase
    end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter  int INDEX_WIDTH       = 6,
    parameter  int WORD_OFFSET_WIDTH = 4,
    localparam int LINE_W            = dcache_pkg::DATA_W << WORD_OFFSET_WIDTH
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_valid,
    input  dcache_pkg::cpu_req_t          i_req,
    output logic                          o_rready,
    output logic                          o_wready,
    output logic [dcache_pkg::DATA_W-1:0] o_rdata,
    output logic                          o_idle,
    output logic                          o_mem_rvalid,
    input  logic                          i_mem_rready,
    output logic [dcache_pkg::ADDR_W-1:0] o_mem_raddr,
    input  logic [LINE_W-1:0]             i_mem_rdata,
    output logic                          o_mem_wvalid,
    input  logic                          i_mem_wready,
    output logic [dcache_pkg::ADDR_W-1:0] o_mem_waddr,
    output logic [LINE_W-1:0]             o_mem_wdata
);
    import dcache_pkg::*;

    localparam int OFF_W = WORD_OFFSET_WIDTH + 2;

    cpu_req_t               lat_req;
    logic [LINE_W/8-1:0]    lat_line_be;
    logic [LINE_W-1:0]      lat_line_wdata;
    logic                   req_take;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [ADDR_W-1:0]      victim_addr;
    logic                   tag_we;
    logic                   dirty_set;
    logic                   dirty_clr;
    logic                   lru_touch;
    logic                   way_sel;
    logic                   store_we;
    logic                   refill_we;
    logic [LINE_W-1:0]      way0_line;
    logic [LINE_W-1:0]      way1_line;
    logic [LINE_W-1:0]      refill_line;
    logic [LINE_W-1:0]      sel_line;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [INDEX_WIDTH-1:0] wr_index;

    assign rd_index = i_req.addr[OFF_W +: INDEX_WIDTH];     // arrays read ahead of the latch
    assign wr_index = lat_req.addr[OFF_W +: INDEX_WIDTH];

    dcache_req_latch #(.WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_req_latch (
        .clk, .rstn, .i_req, .i_take(req_take), .o_lat_req(lat_req),
        .o_line_be(lat_line_be), .o_line_wdata(lat_line_wdata)
    );

    dcache_tag_ways #(
        .INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)
    ) u_tag_ways (
        .clk, .rstn, .i_rd_index(rd_index), .i_lat_req(lat_req),
        .i_tag_we(tag_we), .i_dirty_set(dirty_set), .i_dirty_clr(dirty_clr),
        .i_lru_touch(lru_touch), .i_way_sel(way_sel),
        .o_hit(hit), .o_hit_way(hit_way), .o_victim_way(victim_way),
        .o_victim_dirty(victim_dirty), .o_victim_addr(victim_addr)
    );

    dcache_data_ways #(
        .INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)
    ) u_data_ways (
        .clk, .i_rd_index(rd_index), .i_wr_index(wr_index),
        .i_store_we(store_we), .i_refill_we(refill_we), .i_way_sel(way_sel),
        .i_line_be(lat_line_be), .i_line_wdata(lat_line_wdata),
        .i_refill_line(refill_line), .o_way0_line(way0_line), .o_way1_line(way1_line)
    );

    dcache_miss_ctrl #(.WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_miss_ctrl (
        .clk, .rstn, .i_valid, .i_lat_req(lat_req),
        .i_hit(hit), .i_hit_way(hit_way), .i_victim_way(victim_way),
        .i_victim_dirty(victim_dirty), .i_victim_addr(victim_addr),
        .i_way0_line(way0_line), .i_way1_line(way1_line),
        .i_mem_rready, .i_mem_rdata, .i_mem_wready,
        .o_take(req_take), .o_tag_we(tag_we), .o_dirty_set(dirty_set),
        .o_dirty_clr(dirty_clr), .o_lru_touch(lru_touch), .o_way_sel(way_sel),
        .o_store_we(store_we), .o_refill_we(refill_we),
        .o_refill_line(refill_line), .o_sel_line(sel_line),
        .o_idle, .o_rready, .o_wready,
        .o_mem_rvalid, .o_mem_raddr, .o_mem_wvalid, .o_mem_waddr, .o_mem_wdata
    );

    dcache_load_align #(.WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_load_align (
        .i_line(sel_line), .i_lat_req(lat_req), .o_rdata
    );

endmodule

//--- tb_dcache_top.sv
`timescale 1ns/1ps

module tb_dcache_top;
    import dcache_pkg::*;

    localparam int INDEX_WIDTH       = 6;
    localparam int WORD_OFFSET_WIDTH = 4;
    localparam int LINE_W   = DATA_W << WORD_OFFSET_WIDTH;
    localparam int LINE_B   = LINE_W / 8;
    localparam int OFF_W    = WORD_OFFSET_WIDTH + 2;
    localparam int NUM_TAGS = 4;                          // conflicts in a two-way set
    localparam int NUM_SETS = 4;
    localparam int MEM_AW   = OFF_W + INDEX_WIDTH + 2;    // covers NUM_TAGS tags
    localparam int MEM_SIZE = 1 << MEM_AW;
    localparam int NUM_REQ  = 2000;
    localparam int CLK_PERIOD   = 4;
    localparam int WATCHDOG_CYC = NUM_REQ * 40 + 16 + 8;

    typedef struct packed {
        logic        is_write;
        logic        exp_hit;     // repeated load, must answer next cycle
        logic [31:0] addr;        // request address
        logic [31:0] exp_data;
        logic [31:0] take_cyc;
    } pend_t;

    logic              clk;
    logic              rstn;
    logic              i_valid;
    cpu_req_t          i_req;
    logic              o_rready;
    logic              o_wready;
    logic [DATA_W-1:0] o_rdata;
    logic              o_idle;
    logic              o_mem_rvalid;
    logic              i_mem_rready;
    logic [ADDR_W-1:0] o_mem_raddr;
    logic [LINE_W-1:0] i_mem_rdata;
    logic              o_mem_wvalid;
    logic              i_mem_wready;
    logic [ADDR_W-1:0] o_mem_waddr;
    logic [LINE_W-1:0] o_mem_wdata;

    logic [7:0] mem_bytes [MEM_SIZE];     // backing memory
    logic [7:0] model_bytes [MEM_SIZE];   // what the cpu should see
    pend_t      pend_q [$];
    cpu_req_t   last_req;
    logic       have_last = 1'b0;
    logic       cur_rep = 1'b0;
    logic       running = 1'b0;
    logic       all_done = 1'b0;
    int         seed = 32'h2933378e;
    int         cyc = 0;
    int         taken = 0;
    int         taken_rd = 0;
    int         taken_wr = 0;
    int         rd_pulses = 0;
    int         wr_pulses = 0;
    int         error_cnt = 0;
    int         rd_wait = -1;
    int         wr_wait = -1;

    dcache_top #(
        .INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)
    ) dut0 (
        .clk, .rstn, .i_valid, .i_req, .o_rready, .o_wready, .o_rdata, .o_idle,
        .o_mem_rvalid, .i_mem_rready, .o_mem_raddr, .i_mem_rdata,
        .o_mem_wvalid, .i_mem_wready, .o_mem_waddr, .o_mem_wdata
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            error_cnt++;
            $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    function automatic int rand_range(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // hash spreads every address bit into the byte
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [LINE_W-1:0] line_of(input logic [31:0] a, input logic from_model);
        logic [LINE_W-1:0] l;
        int                base;
        base = int'(a[MEM_AW-1:0]);
        for (int i = 0; i < LINE_B; i++)
            l[8*i +: 8] = from_model ? model_bytes[base + i] : mem_bytes[base + i];
        return l;
    endfunction

    task automatic drive_next();
        cpu_req_t r;
        int       size;
        int       nb;
        int       off;
        logic     rep;
        rep = have_last && (rand_range(4) == 0);
        if (rep) begin
            r      = last_req;
            r.op   = OP_READ;
            r.sext = (rand_range(2) == 1);
        end else begin
            size    = rand_range(3);
            nb      = 1 << size;
            off     = rand_range(LINE_B) & ~(nb - 1);   // natural alignment
            r.op    = (rand_range(5) < 2) ? OP_WRITE : OP_READ;
            r.addr  = (rand_range(NUM_TAGS) << (OFF_W + INDEX_WIDTH))
                    | (rand_range(NUM_SETS) << OFF_W) | off;
            r.wdata = $random(seed);
            r.strb  = (size == 0) ? STRB_BYTE : (size == 1) ? STRB_HALF : STRB_WORD;
            r.sext  = (rand_range(2) == 1);
        end
        i_req   <= r;
        i_valid <= 1'b1;
        cur_rep <= rep;
    endtask

    // stores land in the model when taken and loads read it at the same point
    task automatic accept_request(input cpu_req_t r, input logic rep);
        pend_t       p;
        int          a;
        int          nb;
        logic [31:0] v;
        a  = int'(r.addr[MEM_AW-1:0]);
        nb = (r.strb == STRB_BYTE) ? 1 : (r.strb == STRB_HALF) ? 2 : 4;
        v  = '0;
        for (int i = 0; i < nb; i++) begin
            if (r.op == OP_WRITE)
                model_bytes[a + i] = r.wdata[8*i +: 8];
            else
                v[8*i +: 8] = model_bytes[a + i];
        end
        if (r.sext && nb == 1 && v[7])
            v[31:8] = '1;
        if (r.sext && nb == 2 && v[15])
            v[31:16] = '1;
        if (r.op == OP_WRITE)
            taken_wr++;
        else
            taken_rd++;
        p.is_write = (r.op == OP_WRITE);
        p.exp_hit  = rep;
        p.addr     = r.addr;
        p.exp_data = v;
        p.take_cyc = cyc;
        pend_q.push_back(p);
        last_req  = r;
        have_last = 1'b1;
    endtask

    task automatic collect_ready();
        pend_t p;
        if (o_rready && o_wready) begin
            error_cnt++;
            $display("error at %0t: read and write ready pulsed together", $time);
        end else if (pend_q.size() == 0) begin
            error_cnt++;
            $display("error at %0t: ready pulse with no request outstanding", $time);
        end else begin
            p = pend_q.pop_front();
            check_value("o_wready", o_wready, p.is_write);
            if (o_rready)
                check_value("o_rdata", o_rdata, p.exp_data);
            if (p.exp_hit)
                check_value("hit latency", cyc - p.take_cyc, 1);
        end
    endtask

    // the refill must fetch the line of the request in flight
    task automatic serve_read();
        if (i_mem_rready) begin
            i_mem_rready <= 1'b0;   // transfer on this edge
        end else if (o_mem_rvalid) begin
            if (rd_wait < 0)
                rd_wait = rand_range(6);
            if (rd_wait == 0) begin
                check_value("o_mem_raddr", o_mem_raddr, pend_q[0].addr & ~(LINE_B - 1));
                i_mem_rdata  <= line_of(o_mem_raddr, 1'b0);
                i_mem_rready <= 1'b1;
            end
            rd_wait--;
        end
    endtask

    // victim line must match the model since nothing else touched it
    task automatic serve_write();
        int a;
        a = int'(o_mem_waddr[MEM_AW-1:0]);
        if (i_mem_wready) begin
            check_value("o_mem_wdata", o_mem_wdata, line_of(o_mem_waddr, 1'b1));
            for (int i = 0; i < LINE_B; i++)
                mem_bytes[a + i] = o_mem_wdata[8*i +: 8];
            i_mem_wready <= 1'b0;
        end else if (o_mem_wvalid) begin
            if (wr_wait < 0)
                wr_wait = rand_range(6);
            if (wr_wait == 0) begin
                check_value("o_mem_waddr offset", o_mem_waddr[OFF_W-1:0], '0);
                i_mem_wready <= 1'b1;
            end
            wr_wait--;
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (running) begin
            if (o_rready)
                rd_pulses++;
            if (o_wready)
                wr_pulses++;
            if (o_rready || o_wready)
                collect_ready();   // pulse belongs to the older request
            if (i_valid && (o_idle || o_rready || o_wready)) begin
                accept_request(i_req, cur_rep);
                taken++;
                if (taken == NUM_REQ || rand_range(8) == 0)
                    i_valid <= 1'b0;
                else
                    drive_next();
            end else if (!i_valid && taken < NUM_REQ && rand_range(2) == 0) begin
                drive_next();
            end
            if (taken == NUM_REQ && pend_q.size() == 0)
                all_done <= 1'b1;
            serve_read();
            serve_write();
        end
    end

    initial begin
        rstn         <= 1'b0;
        i_valid      <= 1'b0;
        i_req        <= '0;
        i_mem_rready <= 1'b0;
        i_mem_rdata  <= '0;
        i_mem_wready <= 1'b0;
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem_bytes[a]   = fill_byte(a);
            model_bytes[a] = fill_byte(a);
        end
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            check_value("o_idle", o_idle, 1'b1);
            check_value("o_rready", o_rready, 1'b0);
            check_value("o_wready", o_wready, 1'b0);
            check_value("o_mem_rvalid", o_mem_rvalid, 1'b0);
            check_value("o_mem_wvalid", o_mem_wvalid, 1'b0);
        end
        running <= 1'b1;
        wait (all_done);
        repeat (4) @(posedge clk);   // a stray pulse after the last answer still counts
        check_value("read pulses", rd_pulses, taken_rd);
        check_value("write pulses", wr_pulses, taken_wr);
        $display("errors=%0d taken=%0d read_pulses=%0d write_pulses=%0d",
                 error_cnt, taken, rd_pulses, wr_pulses);
        if (error_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("error: run did not finish in time, %0d of %0d requests taken",
                 taken, NUM_REQ);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- dcache_top.f
dcache_pkg.sv
dcache_req_latch.sv
dcache_tag_ways.sv
dcache_data_ways.sv
dcache_miss_ctrl.sv
dcache_load_align.sv
dcache_top.sv
tb_dcache_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dcache_top
FILELIST = dcache_top.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
